/* src/tinyCore_defines.svh */
`ifndef TINYCORE_DEFINES_SVH
`define TINYCORE_DEFINES_SVH

// Address of the first instruction after reset.
`define TINYCORE_RESET_VECTOR 32'd0

// Program memory holds 2**N words.
`define TINYCORE_PMEM_DEPTH_LOG2 8

`endif

/* src/tinyCorePkg.sv */
package tinyCorePkg;

    // Instruction layout.
    // [31:30] operand kind, [29:28] memory mode, [27:24] Z, [23:20] X.
    // Kinds XYI, XIY, IXY: [19:16] Y, [15:12] op, [11:0] signed immediate.
    // Kind ZXI: Y and op are zero, [19:0] signed immediate.

    typedef logic signed [31:0] word_t;

    typedef logic [3:0] regIdx_t;

    // Comparisons and bit test return all ones for true.
    typedef enum logic [3:0] {
        OP_OR, OP_AND, OP_XOR, OP_ASR, OP_ADD, OP_MUL, OP_EQ, OP_LT,
        OP_ORN, OP_ANDN, OP_PACK, OP_LSR, OP_SUB, OP_SHL, OP_BTST, OP_GE
    } aluOp_t;

    // Order of X, Y and immediate as A, B, C.
    typedef enum logic [1:0] {
        XYI,
        XIY,
        IXY,
        ZXI
    } operandKind_t;

    typedef enum logic [1:0] {
        REG_WRITE,
        STORE_Z_AT_RESULT,
        STORE_RESULT_AT_Z,
        LOAD
    } memMode_t;

endpackage

/* src/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic                 clk,
    input  logic                 writeEn,
    input  tinyCorePkg::regIdx_t writeIdx,
    input  tinyCorePkg::regIdx_t readIdxX,
    input  tinyCorePkg::regIdx_t readIdxY,
    input  tinyCorePkg::regIdx_t readIdxZ,
    input  tinyCorePkg::word_t   writeData,
    input  tinyCorePkg::word_t   nextPc,
    output tinyCorePkg::word_t   readX,
    output tinyCorePkg::word_t   readY,
    output tinyCorePkg::word_t   readZ
);
    import tinyCorePkg::*;

    word_t regs [1:14];

    // Index 0 is constant zero, index 15 mirrors the next fetch address.
    assign readX = (readIdxX == 4'd0) ? '0 : (readIdxX == 4'd15) ? nextPc : regs[readIdxX];
    assign readY = (readIdxY == 4'd0) ? '0 : (readIdxY == 4'd15) ? nextPc : regs[readIdxY];
    assign readZ = (readIdxZ == 4'd0) ? '0 : (readIdxZ == 4'd15) ? nextPc : regs[readIdxZ];

    always_ff @(posedge clk) begin
        if (writeEn && writeIdx != 4'd0 && writeIdx != 4'd15) begin
            regs[writeIdx] <= writeData;
        end
    end

endmodule

/* src/instrDecoder.sv */
`timescale 1ns/100ps

module instrDecoder (
    input  tinyCorePkg::word_t    insn,
    output tinyCorePkg::regIdx_t  idxZ,
    output tinyCorePkg::regIdx_t  idxX,
    output tinyCorePkg::regIdx_t  idxY,
    output tinyCorePkg::aluOp_t   op,
    output tinyCorePkg::memMode_t mode,
    input  tinyCorePkg::word_t    regX,
    input  tinyCorePkg::word_t    regY,
    output tinyCorePkg::word_t    opA,
    output tinyCorePkg::word_t    opB,
    output tinyCorePkg::word_t    opC,
    output logic                  isJump
);
    import tinyCorePkg::*;

    operandKind_t kind;
    word_t        imm;

    assign kind = operandKind_t'(insn[31:30]);
    assign mode = memMode_t'(insn[29:28]);
    assign idxZ = insn[27:24];
    assign idxX = insn[23:20];

    // Long immediate form drops Y and op.
    always_comb begin
        if (kind == ZXI) begin
            idxY = 4'd0;
            op   = OP_OR;
            imm  = {{12{insn[19]}}, insn[19:0]};
        end else begin
            idxY = insn[19:16];
            op   = aluOp_t'(insn[15:12]);
            imm  = {{20{insn[11]}}, insn[11:0]};
        end
    end

    always_comb begin
        case (kind)
            XYI: begin
                opA = regX;
                opB = regY;
                opC = imm;
            end
            XIY: begin
                opA = regX;
                opB = imm;
                opC = regY;
            end
            IXY: begin
                opA = imm;
                opB = regX;
                opC = regY;
            end
            default: begin
                opA = '0;
                opB = regX;
                opC = imm;
            end
        endcase
    end

    // Writing r15 redirects the fetch.
    assign isJump = (idxZ == 4'd15) && (mode == REG_WRITE || mode == LOAD);

endmodule

/* src/aluPipe.sv */
`timescale 1ns/100ps

module aluPipe (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start,
    input  tinyCorePkg::aluOp_t op,
    input  tinyCorePkg::word_t  opA,
    input  tinyCorePkg::word_t  opB,
    input  tinyCorePkg::word_t  opC,
    output logic                done,
    output tinyCorePkg::word_t  result
);
    import tinyCorePkg::*;

    aluOp_t opS1;
    word_t  aS1;
    word_t  bS1;
    word_t  cS1;
    word_t  abS2;
    word_t  cS2;
    word_t  sumS3;
    logic   validS1;
    logic   validS2;
    logic   validS3;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            validS1 <= 1'b0;
            validS2 <= 1'b0;
            validS3 <= 1'b0;
            done    <= 1'b0;
        end else begin
            validS1 <= start;
            validS2 <= validS1;
            validS3 <= validS2;
            done    <= validS3;
        end
    end

    always_ff @(posedge clk) begin
        opS1 <= op;
        aS1  <= opA;
        bS1  <= opB;
        cS1  <= opC;
        cS2  <= cS1;
        case (opS1)
            OP_OR:   abS2 <= aS1 | bS1;
            OP_AND:  abS2 <= aS1 & bS1;
            OP_XOR:  abS2 <= aS1 ^ bS1;
            OP_ASR:  abS2 <= aS1 >>> bS1;
            OP_ADD:  abS2 <= aS1 + bS1;
            OP_MUL:  abS2 <= aS1 * bS1;
            OP_EQ:   abS2 <= {32{aS1 == bS1}};
            OP_LT:   abS2 <= {32{aS1 < bS1}};
            OP_ORN:  abS2 <= aS1 | ~bS1;
            OP_ANDN: abS2 <= aS1 & ~bS1;
            OP_PACK: abS2 <= {aS1[19:0], bS1[11:0]};
            OP_LSR:  abS2 <= aS1 >> bS1;
            OP_SUB:  abS2 <= aS1 - bS1;
            OP_SHL:  abS2 <= aS1 << bS1;
            OP_BTST: abS2 <= {32{(aS1 & (32'sd1 << bS1)) != '0}};
            default: abS2 <= {32{aS1 >= bS1}};
        endcase
        sumS3  <= abS2 + cS2;
        result <= sumS3;
    end

    // Fixed latency in both directions.
    assert property (@(posedge clk) disable iff (!reset_n) start |-> ##4 done);
    assert property (@(posedge clk) disable iff (!reset_n) done |-> $past(start, 4));
    assert property (@(posedge clk) disable iff (!reset_n) !$isunknown(done));

endmodule

/* src/coreControl.sv */
`timescale 1ns/100ps
`include "tinyCore_defines.svh"

module coreControl (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  halt,
    output tinyCorePkg::word_t    fetchAddr,
    input  tinyCorePkg::word_t    fetchData,
    output tinyCorePkg::word_t    insn,
    input  tinyCorePkg::memMode_t mode,
    input  logic                  isJump,
    output logic                  aluStart,
    output tinyCorePkg::word_t    nextPc,
    input  logic                  aluDone,
    input  tinyCorePkg::word_t    aluResult,
    input  tinyCorePkg::word_t    regZ,
    output logic                  regWriteEn,
    output tinyCorePkg::word_t    regWriteData,
    output tinyCorePkg::word_t    dataAddr,
    output tinyCorePkg::word_t    dataOut,
    output logic                  dataWrite,
    output logic                  dataStrobe,
    input  tinyCorePkg::word_t    dataIn
);
    import tinyCorePkg::*;

    typedef enum logic [2:0] {
        FETCH_ADDR,
        FETCH_DATA,
        EXEC_START,
        EXEC_WAIT,
        MEM_SETUP,
        MEM_ACCESS,
        WRITE_BACK
    } state_t;

    state_t state;
    word_t  pc;
    word_t  resultReg;
    word_t  loadWord;
    logic   isStore;
    logic   isLoad;

    assign isStore = (mode == STORE_Z_AT_RESULT) || (mode == STORE_RESULT_AT_Z);
    assign isLoad  = (mode == LOAD);

    // Halt is only honoured between instructions.
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= FETCH_ADDR;
            pc    <= `TINYCORE_RESET_VECTOR;
        end else begin
            case (state)
                FETCH_ADDR: begin
                    if (!halt) begin
                        state <= FETCH_DATA;
                    end
                end
                FETCH_DATA: state <= EXEC_START;
                EXEC_START: state <= EXEC_WAIT;
                EXEC_WAIT: begin
                    if (aluDone) begin
                        state <= MEM_SETUP;
                    end
                end
                MEM_SETUP:  state <= MEM_ACCESS;
                MEM_ACCESS: state <= WRITE_BACK;
                WRITE_BACK: begin
                    state <= FETCH_ADDR;
                    pc    <= isJump ? regWriteData : nextPc;
                end
                default:    state <= FETCH_ADDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_ADDR) begin
            nextPc <= pc + 32'sd1;
        end
        if (state == FETCH_DATA) begin
            insn <= fetchData;
        end
        if (state == EXEC_WAIT && aluDone) begin
            resultReg <= aluResult;
        end
        if (state == MEM_ACCESS) begin
            loadWord <= dataIn;
        end
    end

    assign fetchAddr    = pc;
    assign aluStart     = (state == EXEC_START);
    assign regWriteData = isLoad ? loadWord : resultReg;
    assign regWriteEn   = (state == WRITE_BACK) && !isStore && !isJump;

    // Result is the address except when it is the stored value.
    assign dataAddr   = (mode == STORE_RESULT_AT_Z) ? regZ : resultReg;
    assign dataOut    = (mode == STORE_Z_AT_RESULT) ? regZ : resultReg;
    assign dataWrite  = isStore && (state == MEM_ACCESS);
    assign dataStrobe = (isStore || isLoad) && (state == MEM_ACCESS);

    // Strobe lands in the memory access cycle, two cycles after the ALU finished.
    assert property (@(posedge clk) disable iff (!reset_n)
        dataStrobe |-> state == MEM_ACCESS && $past(aluDone, 2));

endmodule

/* src/progMemory.sv */
`timescale 1ns/100ps
`include "tinyCore_defines.svh"

module progMemory (
    input  logic               clk,
    input  logic               loadValid,
    input  tinyCorePkg::word_t loadAddr,
    input  tinyCorePkg::word_t loadData,
    input  logic               loadEnable,
    output logic               loadReady,
    input  tinyCorePkg::word_t fetchAddr,
    output tinyCorePkg::word_t fetchData
);
    import tinyCorePkg::*;

    localparam int Depth = 1 << `TINYCORE_PMEM_DEPTH_LOG2;

    word_t mem [Depth];

    assign loadReady = loadEnable;

    always_ff @(posedge clk) begin
        if (loadValid && loadReady) begin
            mem[loadAddr[`TINYCORE_PMEM_DEPTH_LOG2-1:0]] <= loadData;
        end
    end

    // Upper address bits wrap.
    assign fetchData = mem[fetchAddr[`TINYCORE_PMEM_DEPTH_LOG2-1:0]];

    // A pending load word stays put until accepted.
    assert property (@(posedge clk) loadValid && !loadReady |=>
        loadValid && $stable(loadAddr) && $stable(loadData));

endmodule

/* src/tinyCoreTop.sv */
`timescale 1ns/100ps

module tinyCoreTop (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               halt,
    input  logic               loadValid,
    input  tinyCorePkg::word_t loadAddr,
    input  tinyCorePkg::word_t loadData,
    output logic               loadReady,
    output tinyCorePkg::word_t dataAddr,
    output tinyCorePkg::word_t dataOut,
    output logic               dataWrite,
    output logic               dataStrobe,
    input  tinyCorePkg::word_t dataIn
);
    import tinyCorePkg::*;

    word_t    fetchAddr;
    word_t    fetchData;
    word_t    insn;
    word_t    nextPc;
    word_t    regX;
    word_t    regY;
    word_t    regZ;
    word_t    opA;
    word_t    opB;
    word_t    opC;
    word_t    aluResult;
    word_t    regWriteData;
    regIdx_t  idxX;
    regIdx_t  idxY;
    regIdx_t  idxZ;
    aluOp_t   op;
    memMode_t mode;
    logic     isJump;
    logic     aluStart;
    logic     aluDone;
    logic     regWriteEn;

    coreControl coreControl_i (
        .clk, .reset_n, .halt, .fetchAddr, .fetchData, .insn, .mode, .isJump,
        .aluStart, .nextPc, .aluDone, .aluResult, .regZ, .regWriteEn, .regWriteData,
        .dataAddr, .dataOut, .dataWrite, .dataStrobe, .dataIn
    );

    regFile regFile_i (
        .clk, .writeEn(regWriteEn), .writeIdx(idxZ), .readIdxX(idxX),
        .readIdxY(idxY), .readIdxZ(idxZ), .writeData(regWriteData), .nextPc,
        .readX(regX), .readY(regY), .readZ(regZ)
    );

    instrDecoder instrDecoder_i (
        .insn, .idxZ, .idxX, .idxY, .op, .mode, .regX, .regY,
        .opA, .opB, .opC, .isJump
    );

    aluPipe aluPipe_i (
        .clk, .reset_n, .start(aluStart), .op, .opA, .opB, .opC,
        .done(aluDone), .result(aluResult)
    );

    // Program loads are only accepted while the core is held.
    progMemory progMemory_i (
        .clk, .loadValid, .loadAddr, .loadData, .loadEnable(halt), .loadReady,
        .fetchAddr, .fetchData
    );

endmodule

/* tb/tinyCoreTb.sv */
`timescale 1ns/100ps

module tinyCoreTb;
    import tinyCorePkg::*;

    localparam word_t StoreAddr = 32'sd40;

    logic  clk = 1'b0;
    logic  reset_n;
    logic  halt;
    logic  loadValid;
    word_t loadAddr;
    word_t loadData;
    logic  loadReady;
    word_t dataAddr;
    word_t dataOut;
    logic  dataWrite;
    logic  dataStrobe;
    word_t dataIn;

    word_t       dataMem [64];
    word_t       progWords [$];
    logic [31:0] rngState = 32'ha883_6563;
    int          checks = 0;
    int          errors = 0;
    int          loadedWords = 0;

    tinyCoreTop tinyCoreTop_i (
        .clk, .reset_n, .halt, .loadValid, .loadAddr, .loadData, .loadReady,
        .dataAddr, .dataOut, .dataWrite, .dataStrobe, .dataIn
    );

    always #50 clk = ~clk;

    // Data memory model answering reads in the strobe cycle.
    assign dataIn = dataMem[dataAddr[5:0]];

    always @(negedge clk) begin
        if (dataStrobe && dataWrite) begin
            dataMem[dataAddr[5:0]] <= dataOut;
        end
    end

    function automatic word_t fillWord(int addr);
        return 32'h9e37_79b9 * (addr + 1);
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [19:0] randImm20();
        logic [31:0] r;
        r = nextRandom();
        return r[19:0];
    endfunction

    function automatic logic [11:0] randImm12();
        logic [31:0] r;
        r = nextRandom();
        return r[11:0];
    endfunction

    function automatic word_t sext20(logic [19:0] v);
        return {{12{v[19]}}, v};
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t shortInsn(operandKind_t kind, memMode_t mode, regIdx_t z,
                                        regIdx_t x, regIdx_t y, aluOp_t op, logic [11:0] imm);
        return {kind, mode, z, x, y, op, imm};
    endfunction

    function automatic word_t longInsn(memMode_t mode, regIdx_t z, regIdx_t x,
                                       logic [19:0] imm);
        return {ZXI, mode, z, x, imm};
    endfunction

    // Expected (A op B) + C. Shift amounts are kept below 32 by the tests.
    function automatic word_t refAlu(aluOp_t op, word_t a, word_t b, word_t c);
        word_t ab;
        int    amt;
        amt = b[4:0];
        case (op)
            OP_OR:   ab = a | b;
            OP_AND:  ab = a & b;
            OP_XOR:  ab = a ^ b;
            OP_ASR:  ab = a >>> amt;
            OP_ADD:  ab = a + b;
            OP_MUL:  ab = a * b;
            OP_EQ:   ab = (a == b) ? '1 : '0;
            OP_LT:   ab = (a < b) ? '1 : '0;
            OP_ORN:  ab = a | ~b;
            OP_ANDN: ab = a & ~b;
            OP_PACK: ab = (a << 12) | (b & 32'h0000_0fff);
            OP_LSR:  ab = a >> amt;
            OP_SUB:  ab = a - b;
            OP_SHL:  ab = a << amt;
            OP_BTST: ab = a[amt] ? '1 : '0;
            default: ab = (a >= b) ? '1 : '0;
        endcase
        return ab + c;
    endfunction

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkWrite(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic reportError(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Halt and reset the core, load progWords, then let it run from the reset vector.
    task automatic runProgram();
        @(negedge clk);
        halt = 1'b1;
        reset_n = 1'b0;
        for (int i = 0; i < progWords.size(); i++) begin
            loadAddr = i;
            loadData = progWords[i];
            loadValid = 1'b1;
            @(posedge clk);
            while (!loadReady) begin
                @(posedge clk);
            end
            @(negedge clk);
        end
        loadValid = 1'b0;
        loadedWords += progWords.size();
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        halt = 1'b0;
    endtask

    task automatic expectAccess(input word_t addr, input word_t data, input logic write);
        @(negedge clk);
        while (!dataStrobe) begin
            @(negedge clk);
        end
        checkWrite("dataWrite", dataWrite, write);
        checkAddr("dataAddr", dataAddr, addr);
        if (write) begin
            checkWord("dataOut", dataOut, data);
        end
    endtask

    task automatic testAluOps();
        word_t       expected [16];
        logic [19:0] xImm;
        logic [19:0] yImm;
        logic [19:0] shiftImm;
        logic [11:0] cImm;
        aluOp_t      op;
        regIdx_t     yReg;
        word_t       bValue;
        xImm = randImm20();
        yImm = randImm20();
        shiftImm = randImm20() & 20'h0001f;
        progWords = {};
        progWords.push_back(longInsn(REG_WRITE, 4'd1, 4'd0, xImm));
        progWords.push_back(longInsn(REG_WRITE, 4'd2, 4'd0, yImm));
        progWords.push_back(longInsn(REG_WRITE, 4'd4, 4'd0, shiftImm));
        progWords.push_back(longInsn(REG_WRITE, 4'd3, 4'd0, 20'd40));
        for (int i = 0; i < 16; i++) begin
            op = aluOp_t'(i);
            if (op == OP_ASR || op == OP_LSR || op == OP_SHL || op == OP_BTST) begin
                yReg = 4'd4;
                bValue = sext20(shiftImm);
            end else begin
                yReg = 4'd2;
                bValue = sext20(yImm);
            end
            cImm = randImm12();
            expected[i] = refAlu(op, sext20(xImm), bValue, sext12(cImm));
            progWords.push_back(shortInsn(XYI, STORE_RESULT_AT_Z, 4'd3, 4'd1, yReg, op, cImm));
        end
        progWords.push_back(longInsn(REG_WRITE, 4'd15, 4'd15, 20'hfffff));
        runProgram();
        for (int i = 0; i < 16; i++) begin
            expectAccess(StoreAddr, expected[i], 1'b1);
        end
    endtask

    task automatic testOperandKinds();
        logic [19:0] xImm;
        logic [19:0] yImm;
        logic [19:0] longImm;
        logic [11:0] cImm;
        word_t       vx;
        word_t       vy;
        word_t       vi;
        xImm = randImm20();
        yImm = randImm20();
        longImm = randImm20();
        cImm = randImm12();
        vx = sext20(xImm);
        vy = sext20(yImm);
        vi = sext12(cImm);
        progWords = {};
        progWords.push_back(longInsn(REG_WRITE, 4'd1, 4'd0, xImm));
        progWords.push_back(longInsn(REG_WRITE, 4'd2, 4'd0, yImm));
        progWords.push_back(longInsn(REG_WRITE, 4'd3, 4'd0, 20'd40));
        progWords.push_back(shortInsn(XYI, STORE_RESULT_AT_Z, 4'd3, 4'd1, 4'd2, OP_SUB, cImm));
        progWords.push_back(shortInsn(XIY, STORE_RESULT_AT_Z, 4'd3, 4'd1, 4'd2, OP_SUB, cImm));
        progWords.push_back(shortInsn(IXY, STORE_RESULT_AT_Z, 4'd3, 4'd1, 4'd2, OP_SUB, cImm));
        progWords.push_back(longInsn(STORE_RESULT_AT_Z, 4'd3, 4'd1, longImm));
        progWords.push_back(longInsn(STORE_Z_AT_RESULT, 4'd1, 4'd0, 20'd12));
        progWords.push_back(longInsn(REG_WRITE, 4'd15, 4'd15, 20'hfffff));
        runProgram();
        expectAccess(StoreAddr, refAlu(OP_SUB, vx, vy, vi), 1'b1);
        expectAccess(StoreAddr, refAlu(OP_SUB, vx, vi, vy), 1'b1);
        expectAccess(StoreAddr, refAlu(OP_SUB, vi, vx, vy), 1'b1);
        expectAccess(StoreAddr, refAlu(OP_OR, '0, vx, sext20(longImm)), 1'b1);
        expectAccess(32'sd12, vx, 1'b1);
    endtask

    task automatic testZeroAndLoad();
        word_t loaded;
        loaded = dataMem[20];
        progWords = {};
        progWords.push_back(longInsn(REG_WRITE, 4'd3, 4'd0, 20'd40));
        progWords.push_back(longInsn(REG_WRITE, 4'd0, 4'd0, 20'd77));
        progWords.push_back(longInsn(STORE_RESULT_AT_Z, 4'd3, 4'd0, 20'd0));
        progWords.push_back(longInsn(LOAD, 4'd5, 4'd0, 20'd20));
        progWords.push_back(longInsn(STORE_RESULT_AT_Z, 4'd3, 4'd5, 20'd0));
        progWords.push_back(longInsn(REG_WRITE, 4'd15, 4'd15, 20'hfffff));
        runProgram();
        expectAccess(StoreAddr, '0, 1'b1);
        expectAccess(32'sd20, '0, 1'b0);
        expectAccess(StoreAddr, loaded, 1'b1);
    endtask

    // The store at address 2 is jumped over, the next one stores r15.
    task automatic testJump();
        progWords = {};
        progWords.push_back(longInsn(REG_WRITE, 4'd3, 4'd0, 20'd40));
        progWords.push_back(longInsn(REG_WRITE, 4'd15, 4'd15, 20'd1));
        progWords.push_back(longInsn(STORE_RESULT_AT_Z, 4'd3, 4'd0, 20'd111));
        progWords.push_back(longInsn(STORE_RESULT_AT_Z, 4'd3, 4'd15, 20'd0));
        progWords.push_back(longInsn(REG_WRITE, 4'd15, 4'd15, 20'hfffff));
        runProgram();
        expectAccess(StoreAddr, 32'sd4, 1'b1);
    endtask

    task automatic testHalt();
        progWords = {};
        progWords.push_back(longInsn(REG_WRITE, 4'd3, 4'd0, 20'd40));
        progWords.push_back(longInsn(STORE_RESULT_AT_Z, 4'd3, 4'd15, 20'd0));
        progWords.push_back(longInsn(REG_WRITE, 4'd15, 4'd15, 20'hffffe));
        runProgram();
        expectAccess(StoreAddr, 32'sd2, 1'b1);
        halt = 1'b1;
        // Longer than one pass of the loop.
        repeat (40) begin
            @(negedge clk);
            if (dataStrobe) begin
                reportError("data strobe seen while the core is halted");
            end
            if (!loadReady) begin
                reportError("load port not ready while the core is halted");
            end
        end
        halt = 1'b0;
        expectAccess(StoreAddr, 32'sd2, 1'b1);
    endtask

    task automatic testResetRestart();
        progWords = {};
        progWords.push_back(longInsn(REG_WRITE, 4'd3, 4'd0, 20'd40));
        progWords.push_back(longInsn(STORE_RESULT_AT_Z, 4'd3, 4'd0, 20'h00123));
        progWords.push_back(longInsn(STORE_RESULT_AT_Z, 4'd3, 4'd15, 20'd0));
        progWords.push_back(longInsn(REG_WRITE, 4'd15, 4'd15, 20'hfffff));
        runProgram();
        expectAccess(StoreAddr, 32'sh123, 1'b1);
        reset_n = 1'b0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        expectAccess(StoreAddr, 32'sh123, 1'b1);
        expectAccess(StoreAddr, 32'sd3, 1'b1);
    endtask

    // Budget grows with every instruction word loaded.
    initial begin : watchdog
        longint cycles;
        cycles = 0;
        while (cycles <= 2000 * (loadedWords + 1)) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the core stopped making progress", cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = fillWord(i);
        end
        reset_n = 1'b0;
        halt = 1'b1;
        loadValid = 1'b0;
        loadAddr = '0;
        loadData = '0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        testAluOps();
        testOperandKinds();
        testZeroAndLoad();
        testJump();
        testHalt();
        testResetRestart();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tinyCore.f */
+incdir+src
src/tinyCorePkg.sv
src/regFile.sv
src/instrDecoder.sv
src/aluPipe.sv
src/coreControl.sv
src/progMemory.sv
src/tinyCoreTop.sv
tb/tinyCoreTb.sv

/* Bender.yml */
package:
  name: tinyCore

sources:
  - include_dirs:
      - src
    files:
      - src/tinyCorePkg.sv
      - src/regFile.sv
      - src/instrDecoder.sv
      - src/aluPipe.sv
      - src/coreControl.sv
      - src/progMemory.sv
      - src/tinyCoreTop.sv
  - target: test
    files:
      - tb/tinyCoreTb.sv
